// File: Bender.yml
package:
  name: fp_add

sources:
  - source/fp_add_pkg.sv
  - source/fp_operand_classify.sv
  - source/fp_special_path.sv
  - source/fp_finite_path.sv
  - source/fp_result_merge.sv
  - source/fp_add_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/fp_add_checker.sv
      - verification/tb_fp_add.sv

// File: flist.f
source/fp_add_pkg.sv
source/fp_operand_classify.sv
source/fp_special_path.sv
source/fp_finite_path.sv
source/fp_result_merge.sv
source/fp_add_top.sv
verification/tb_clock_gen.sv
verification/fp_add_checker.sv
verification/tb_fp_add.sv

// File: source/fp_add_pkg.sv
`default_nettype none

package fp_add_pkg;

    // binary32 word and its fields
    typedef logic [31:0] fp32_t;
    typedef logic [7:0]  fp_exp_t;
    typedef logic [22:0] fp_sig_t;

    // one decoded operand
    typedef struct packed {
        logic    sign;
        fp_exp_t exp;
        fp_sig_t sig;
        logic    zero;
        logic    inf;
        logic    nan;
        logic    snan;
        logic    qnan;
        logic    subnormal;
    } fp_class_t;

    typedef enum logic [2:0] {
        RND_RNE = 3'd0,
        RND_RNA = 3'd1,
        RND_RTP = 3'd2,
        RND_RTN = 3'd3,
        RND_RTZ = 3'd4
    } round_mode_t;

    // invalid, overflow, inexact
    typedef struct packed {
        logic nv;
        logic of;
        logic nx;
    } fp_flags_t;

    typedef struct packed {
        logic        sub;
        round_mode_t rnd;
        fp32_t       a;
        fp32_t       b;
    } fp_req_t;

    typedef struct packed {
        fp32_t     result;
        fp_flags_t flags;
    } fp_rsp_t;

    // classify to both second-stage paths
    typedef struct packed {
        fp_class_t   a;
        fp_class_t   b;
        logic        eff_sub;
        round_mode_t rnd;
    } fp_stage_t;

    // second-stage path to merge
    typedef struct packed {
        fp32_t     result;
        fp_flags_t flags;
    } fp_path_t;

    localparam fp32_t FP_QNAN    = 32'h7fc00000;
    localparam fp32_t FP_POS_MAX = 32'h7f7fffff;
    localparam fp32_t FP_NEG_MAX = 32'hff7fffff;
    localparam fp32_t FP_POS_INF = 32'h7f800000;
    localparam fp32_t FP_NEG_INF = 32'hff800000;

endpackage

`default_nettype wire

// File: source/fp_add_top.sv
`timescale 1ns/1ps
`default_nettype none

module fp_add_top (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_req_valid,
    input  fp_add_pkg::fp_req_t i_req,
    output logic                o_rsp_valid,
    output fp_add_pkg::fp_rsp_t o_rsp
);
    import fp_add_pkg::*;

    logic      stage_valid;
    fp_stage_t stage;
    logic      special_valid;
    logic      special_take;
    fp_path_t  special_path;
    fp_path_t  finite_path;

    fp_operand_classify fp_operand_classify_inst (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req_valid   (i_req_valid),
        .i_req         (i_req),
        .o_stage_valid (stage_valid),
        .o_stage       (stage)
    );

    // both paths read the same stage register
    fp_special_path fp_special_path_inst (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_stage_valid (stage_valid),
        .i_stage       (stage),
        .o_valid       (special_valid),
        .o_take        (special_take),
        .o_path        (special_path)
    );

    fp_finite_path fp_finite_path_inst (
        .i_clk   (i_clk),
        .i_stage (stage),
        .o_path  (finite_path)
    );

    fp_result_merge fp_result_merge_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (special_valid),
        .i_take      (special_take),
        .i_special   (special_path),
        .i_finite    (finite_path),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp       (o_rsp)
    );

endmodule

`default_nettype wire

// File: source/fp_finite_path.sv
`timescale 1ns/1ps
`default_nettype none

module fp_finite_path (
    input  logic                  i_clk,
    input  fp_add_pkg::fp_stage_t i_stage,
    output fp_add_pkg::fp_path_t  o_path
);
    import fp_add_pkg::*;

    logic        b_sign;
    logic        a_bigger;
    logic [23:0] man_a;
    logic [23:0] man_b;
    fp_exp_t     exp_a;
    fp_exp_t     exp_b;
    logic [23:0] man_big;
    logic [23:0] man_small;
    fp_exp_t     exp_big;
    fp_exp_t     exp_small;
    logic        sign_big;
    fp_exp_t     exp_diff;
    logic [4:0]  shamt;
    logic [50:0] small_ext;
    logic [26:0] big_al;
    logic [26:0] small_al;
    logic [27:0] sum;
    logic [4:0]  lz;
    logic [4:0]  nshift;
    logic [26:0] norm;
    logic [9:0]  exp_norm;
    logic        inexact;
    logic        round_up;
    logic [24:0] rounded;
    logic [9:0]  exp_rnd;
    logic        overflow;
    fp_path_t    path;

    function automatic logic [4:0] count_lz(input logic [26:0] v);
        logic [4:0] n;
        logic       found;
        n     = 5'd27;
        found = 1'b0;
        for (int i = 26; i >= 0; i--) begin
            if (!found && v[i]) begin
                n     = 5'(26 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    assign b_sign = i_stage.a.sign ^ i_stage.eff_sub;

    // subnormals carry no hidden bit and sit at exponent 1
    assign man_a = {!i_stage.a.subnormal, i_stage.a.sig};
    assign man_b = {!i_stage.b.subnormal, i_stage.b.sig};
    assign exp_a = i_stage.a.subnormal ? 8'd1 : i_stage.a.exp;
    assign exp_b = i_stage.b.subnormal ? 8'd1 : i_stage.b.exp;

    // raw exponent and significand order the same as magnitude
    assign a_bigger  = {i_stage.a.exp, i_stage.a.sig} >= {i_stage.b.exp, i_stage.b.sig};
    assign man_big   = a_bigger ? man_a : man_b;
    assign man_small = a_bigger ? man_b : man_a;
    assign exp_big   = a_bigger ? exp_a : exp_b;
    assign exp_small = a_bigger ? exp_b : exp_a;
    assign sign_big  = a_bigger ? i_stage.a.sign : b_sign;

    // align the smaller operand, keeping guard, round and sticky
    assign exp_diff  = exp_big - exp_small;
    assign shamt     = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];
    assign small_ext = {man_small, 27'd0} >> shamt;
    assign small_al  = {small_ext[50:25], |small_ext[24:0]};
    assign big_al    = {man_big, 3'b000};

    assign sum = i_stage.eff_sub ? ({1'b0, big_al} - {1'b0, small_al})
                                 : ({1'b0, big_al} + {1'b0, small_al});

    // left shift stops at exponent 1 so the result may stay subnormal
    assign lz     = count_lz(sum[26:0]);
    assign nshift = (8'(lz) < exp_big) ? lz : 5'(exp_big - 8'd1);

    always_comb begin
        if (sum[27]) begin
            norm     = {sum[27:2], sum[1] | sum[0]};
            exp_norm = {2'b00, exp_big} + 10'd1;
        end else begin
            norm     = sum[26:0] << nshift;
            exp_norm = {2'b00, exp_big} - {5'd0, nshift};
        end
    end

    assign inexact = |norm[2:0];

    always_comb begin
        case (i_stage.rnd)
            RND_RNE: round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
            RND_RNA: round_up = norm[2];
            RND_RTP: round_up = !sign_big & inexact;
            RND_RTN: round_up = sign_big & inexact;
            default: round_up = 1'b0;
        endcase
    end

    // a carry out of the significand bumps the exponent
    assign rounded  = {1'b0, norm[26:3]} + {24'd0, round_up};
    assign exp_rnd  = exp_norm + {9'd0, rounded[24]};
    assign overflow = (exp_rnd >= 10'd255);

    always_comb begin
        path.flags.nv = 1'b0;
        path.flags.of = 1'b0;
        path.flags.nx = inexact;
        if (sum == 28'd0) begin
            // exact cancellation
            path.result   = {i_stage.rnd == RND_RTN, 31'd0};
            path.flags.nx = 1'b0;
        end else if (overflow) begin
            path.flags.of = 1'b1;
            path.flags.nx = 1'b1;
            case (i_stage.rnd)
                RND_RTZ: path.result = sign_big ? FP_NEG_MAX : FP_POS_MAX;
                RND_RTP: path.result = sign_big ? FP_NEG_MAX : FP_POS_INF;
                RND_RTN: path.result = sign_big ? FP_NEG_INF : FP_POS_MAX;
                default: path.result = sign_big ? FP_NEG_INF : FP_POS_INF;
            endcase
        end else if (rounded[24] || rounded[23]) begin
            path.result = {sign_big, exp_rnd[7:0], rounded[22:0]};
        end else begin
            path.result = {sign_big, 8'd0, rounded[22:0]};
        end
    end

    always_ff @(posedge i_clk) begin
        o_path <= path;
    end

endmodule

`default_nettype wire

// File: source/fp_operand_classify.sv
`timescale 1ns/1ps
`default_nettype none

module fp_operand_classify (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_req_valid,
    input  fp_add_pkg::fp_req_t   i_req,
    output logic                  o_stage_valid,
    output fp_add_pkg::fp_stage_t o_stage
);
    import fp_add_pkg::*;

    fp_class_t class_a;
    fp_class_t class_b;
    logic      eff_sub;

    // split a word into fields and class bits
    function automatic fp_class_t classify(input fp32_t w);
        fp_class_t c;
        logic      exp_ones;
        logic      sig_zero;
        exp_ones    = (w[30:23] == 8'hff);
        sig_zero    = (w[22:0] == 23'd0);
        c.sign      = w[31];
        c.exp       = w[30:23];
        c.sig       = w[22:0];
        c.zero      = (w[30:0] == 31'd0);
        c.inf       = exp_ones && sig_zero;
        c.nan       = exp_ones && !sig_zero;
        // top significand bit clear marks a signalling NaN
        c.snan      = c.nan && !w[22];
        c.qnan      = c.nan && w[22];
        c.subnormal = (w[30:23] == 8'h00) && !sig_zero;
        return c;
    endfunction

    assign class_a = classify(i_req.a);
    assign class_b = classify(i_req.b);

    // signs disagree after applying the operation
    assign eff_sub = i_req.sub ^ i_req.a[31] ^ i_req.b[31];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_stage_valid <= 1'b0;
        end else begin
            o_stage_valid <= i_req_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req_valid) begin
            o_stage.a       <= class_a;
            o_stage.b       <= class_b;
            o_stage.eff_sub <= eff_sub;
            o_stage.rnd     <= i_req.rnd;
        end
    end

endmodule

`default_nettype wire

// File: source/fp_result_merge.sv
`timescale 1ns/1ps
`default_nettype none

module fp_result_merge (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_valid,
    input  logic                 i_take,
    input  fp_add_pkg::fp_path_t i_special,
    input  fp_add_pkg::fp_path_t i_finite,
    output logic                 o_rsp_valid,
    output fp_add_pkg::fp_rsp_t  o_rsp
);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= i_valid;
        end
    end

    // special operands override whatever the finite path produced
    always_ff @(posedge i_clk) begin
        if (i_take) begin
            o_rsp.result <= i_special.result;
            o_rsp.flags  <= i_special.flags;
        end else begin
            o_rsp.result <= i_finite.result;
            o_rsp.flags  <= i_finite.flags;
        end
    end

endmodule

`default_nettype wire

// File: source/fp_special_path.sv
`timescale 1ns/1ps
`default_nettype none

module fp_special_path (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_stage_valid,
    input  fp_add_pkg::fp_stage_t i_stage,
    output logic                  o_valid,
    output logic                  o_take,
    output fp_add_pkg::fp_path_t  o_path
);
    import fp_add_pkg::*;

    logic      b_sign;
    logic      any_nan;
    logic      take;
    fp_path_t  path;

    // sign of b once the operation is folded in
    assign b_sign  = i_stage.a.sign ^ i_stage.eff_sub;
    assign any_nan = i_stage.a.nan | i_stage.b.nan;
    assign take    = any_nan | i_stage.a.inf | i_stage.b.inf
                   | i_stage.a.zero | i_stage.b.zero;

    always_comb begin
        path.result   = 32'd0;
        path.flags.nv = 1'b0;
        path.flags.of = 1'b0;
        path.flags.nx = 1'b0;
        if (any_nan) begin
            path.result   = FP_QNAN;
            path.flags.nv = i_stage.a.snan | i_stage.b.snan;
        end else if (i_stage.a.inf && i_stage.b.inf && i_stage.eff_sub) begin
            // inf - inf
            path.result   = FP_QNAN;
            path.flags.nv = 1'b1;
        end else if (i_stage.a.inf) begin
            path.result = {i_stage.a.sign, 8'hff, 23'd0};
        end else if (i_stage.b.inf) begin
            path.result = {b_sign, 8'hff, 23'd0};
        end else if (i_stage.a.zero && i_stage.b.zero) begin
            // opposite zeros only go negative when rounding down
            path.result = {i_stage.eff_sub ? (i_stage.rnd == RND_RTN) : i_stage.a.sign,
                           31'd0};
        end else if (i_stage.a.zero) begin
            path.result = {b_sign, i_stage.b.exp, i_stage.b.sig};
        end else if (i_stage.b.zero) begin
            path.result = {i_stage.a.sign, i_stage.a.exp, i_stage.a.sig};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_stage_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_take <= take;
        o_path <= path;
    end

endmodule

`default_nettype wire

// File: verification/fp_add_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fp_add_checker (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_req_valid,
    input  fp_add_pkg::fp_rsp_t i_exp_rsp,
    input  logic                i_rsp_valid,
    input  fp_add_pkg::fp_rsp_t i_rsp,
    output int                  o_error_count,
    output int                  o_rsp_count
);
    import fp_add_pkg::*;

    localparam int LATENCY = 3;

    fp_rsp_t exp_queue[$];
    int      cycle_queue[$];
    fp_rsp_t expected;
    int      req_cycle;
    int      cycle;

    always @(posedge i_clk) begin
        if (i_rst) begin
            o_error_count = 0;
            o_rsp_count   = 0;
            cycle         = 0;
            exp_queue.delete();
            cycle_queue.delete();
        end else begin
            cycle = cycle + 1;
            // a response can never belong to a request seen in the same cycle
            if (i_rsp_valid) begin
                o_rsp_count = o_rsp_count + 1;
                if (exp_queue.size() == 0) begin
                    $display("response %0d arrived at cycle %0d with no request outstanding",
                             o_rsp_count, cycle);
                    o_error_count = o_error_count + 1;
                end else begin
                    expected  = exp_queue.pop_front();
                    req_cycle = cycle_queue.pop_front();
                    if (cycle - req_cycle != LATENCY) begin
                        $display("response %0d came %0d cycles after its request, not %0d",
                                 o_rsp_count, cycle - req_cycle, LATENCY);
                        o_error_count = o_error_count + 1;
                    end
                    if (i_rsp.result !== expected.result) begin
                        $display("** Error: o_rsp.result vector %0d expected %h got %h",
                                 o_rsp_count, expected.result, i_rsp.result);
                        o_error_count = o_error_count + 1;
                    end
                    if (i_rsp.flags !== expected.flags) begin
                        $display("** Error: o_rsp.flags vector %0d expected %h got %h",
                                 o_rsp_count, expected.flags, i_rsp.flags);
                        o_error_count = o_error_count + 1;
                    end
                end
            end
            if (i_req_valid) begin
                exp_queue.push_back(i_exp_rsp);
                cycle_queue.push_back(cycle);
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/fp_add_testdata.txt
// op rnd a b result flags idle (op 1 is subtract, rnd 0..4 is rne rna rtp rtn rtz)
// flags hold nv of nx from msb down, idle is the count of empty cycles before the vector
0 0 3f800000 3f800000 40000000 0 0
0 2 3fc00000 40200000 40800000 0 1
1 3 3f800000 40000000 bf800000 0 0
1 4 41200000 3f800000 41100000 0 2
0 1 00000001 00000001 00000002 0 0
1 1 00800000 00000001 007fffff 0 0
1 3 3f800000 3f800000 80000000 0 1
0 0 40400000 40000001 40a00000 1 2
0 1 40400000 40000001 40a00001 1 0
0 2 40400000 40000001 40a00001 1 0
0 3 40400000 40000001 40a00000 1 0
0 4 40400000 40000001 40a00000 1 0
0 0 c0400000 40000001 bf7ffffc 0 0
0 1 c0400000 40000001 bf7ffffc 0 0
0 2 c0400000 40000001 bf7ffffc 0 0
0 3 c0400000 40000001 bf7ffffc 0 0
0 4 c0400000 40000001 bf7ffffc 0 0
0 0 c0400000 c0000001 c0a00000 1 0
0 1 c0400000 c0000001 c0a00001 1 0
0 2 c0400000 c0000001 c0a00000 1 0
0 3 c0400000 c0000001 c0a00001 1 0
0 4 c0400000 c0000001 c0a00000 1 0
0 0 7f400000 7f400000 7f800000 3 1
0 3 7f400000 7f400000 7f7fffff 3 0
0 4 7f400000 7f400000 7f7fffff 3 0
0 1 ff400000 ff400000 ff800000 3 0
0 2 ff400000 ff400000 ff7fffff 3 0
0 3 ff400000 ff400000 ff800000 3 0
0 0 7fa00000 3f800000 7fc00000 4 3
0 2 3f800000 ffc00001 7fc00000 0 0
1 4 7f800000 7f800000 7fc00000 4 0
0 3 7f800000 ff800000 7fc00000 4 0
0 0 00000000 80000000 00000000 0 1
0 3 00000000 80000000 80000000 0 0
0 2 80000000 80000000 80000000 0 0
1 3 00000000 00000000 80000000 0 0
0 1 7f800000 3f800000 7f800000 0 0
1 4 3f800000 7f800000 ff800000 0 0
1 0 00000000 40490fdb c0490fdb 0 0
0 2 00000001 00000000 00000001 0 0

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

    // reset held high for a fixed number of rising edges
    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/tb_fp_add.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_add;
    import fp_add_pkg::*;

    localparam int PERIOD_NS    = 4;
    localparam int RESET_CYCLES = 16;
    localparam int FIELDS       = 7;
    localparam int MAX_VECTORS  = 64;

    logic        clk;
    logic        rst;
    logic        req_valid;
    fp_req_t     req;
    fp_rsp_t     exp_rsp;
    logic        rsp_valid;
    fp_rsp_t     rsp;
    int          error_count;
    int          rsp_count;
    logic [31:0] vec_mem [0:FIELDS*MAX_VECTORS-1];
    int          num_vectors;
    int          idle_total;
    int          base;
    logic        loaded;
    fp_req_t     next_req;
    fp_rsp_t     next_exp;

    tb_clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen_inst (
        .o_clk (clk),
        .o_rst (rst)
    );

    fp_add_top fp_add_top_inst (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_req_valid (req_valid),
        .i_req       (req),
        .o_rsp_valid (rsp_valid),
        .o_rsp       (rsp)
    );

    fp_add_checker checker_inst (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_req_valid   (req_valid),
        .i_exp_rsp     (exp_rsp),
        .i_rsp_valid   (rsp_valid),
        .i_rsp         (rsp),
        .o_error_count (error_count),
        .o_rsp_count   (rsp_count)
    );

    initial begin
        req_valid   = 1'b0;
        req         = '0;
        exp_rsp     = '0;
        loaded      = 1'b0;
        num_vectors = 0;
        idle_total  = 0;
        // unused entries carry ff in the top byte, which no op column holds
        for (int k = 0; k < FIELDS * MAX_VECTORS; k++) begin
            vec_mem[k] = 32'hff000000 | 32'(k);
        end
        $readmemh("verification/fp_add_testdata.txt", vec_mem);
        while (num_vectors < MAX_VECTORS && vec_mem[num_vectors * FIELDS][31:24] != 8'hff) begin
            idle_total  = idle_total + int'(vec_mem[num_vectors * FIELDS + 6]);
            num_vectors = num_vectors + 1;
        end
        loaded = 1'b1;
        if (num_vectors == 0) begin
            $display("no test vectors could be read from the data file");
        end

        @(negedge rst);
        for (int v = 0; v < num_vectors; v++) begin
            base = v * FIELDS;
            for (int g = 0; g < int'(vec_mem[base + 6]); g++) begin
                @(posedge clk);
                req_valid <= 1'b0;
            end
            next_req.sub    = vec_mem[base][0];
            next_req.rnd    = round_mode_t'(vec_mem[base + 1][2:0]);
            next_req.a      = vec_mem[base + 2];
            next_req.b      = vec_mem[base + 3];
            next_exp.result = vec_mem[base + 4];
            next_exp.flags  = vec_mem[base + 5][2:0];
            @(posedge clk);
            req_valid <= 1'b1;
            req       <= next_req;
            exp_rsp   <= next_exp;
        end
        @(posedge clk);
        req_valid <= 1'b0;

        wait (rsp_count >= num_vectors);
        // a few more cycles to catch any stray response
        repeat (5) @(negedge clk);
        $display("errors: %0d, vectors: %0d, responses: %0d",
                 error_count, num_vectors, rsp_count);
        if (error_count == 0 && num_vectors > 0 && rsp_count == num_vectors) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog sized from reset, idle gaps and vector count
    initial begin
        wait (loaded);
        #((num_vectors + idle_total + RESET_CYCLES + 50) * PERIOD_NS);
        $display("timeout with %0d of %0d responses received", rsp_count, num_vectors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
